// File: common/nebula_pkg.sv
// ##################################################
// Memory map and sizes for the two-team user area
// Region code sits in address bits 15:12, upper bits are not decoded
// ##################################################
package nebula_pkg;

    localparam int NUM_TEAMS  = 2;    // Team slot 0 means no owner
    localparam int SRAM_WORDS = 256;

    localparam logic [3:0] REGION_SRAM = 4'd0;
    localparam logic [3:0] REGION_GPIO = 4'd1;
    localparam logic [3:0] REGION_LA   = 4'd2;
    localparam logic [3:0] REGION_TEAM = 4'd3;

    localparam int GPIO_PINS  = 38;
    localparam int GPIO_BANK  = 8;
    localparam int GPIO_BANKS = (GPIO_PINS + GPIO_BANK - 1) / GPIO_BANK;  // Last bank is short

    localparam int LA_BANKS = 4;
    localparam int LA_WIDTH = 32 * LA_BANKS;

    localparam logic [31:0] UNMAPPED_DATA = 32'hBAD0_ADD5;

    // Same address word, seen by system targets or by team slots
    typedef union packed {
        struct packed {
            logic [15:0] upper;
            logic [3:0]  region;
            logic [9:0]  word;
            logic [1:0]  byte_off;
        } sys_view;
        struct packed {
            logic [15:0] upper;
            logic [3:0]  region;
            logic [3:0]  team;
            logic [5:0]  reg_num;
            logic [1:0]  byte_off;
        } team_view;
    } wb_addr_u;

    // Byte-lane write merge for sel
    function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  sel);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

endpackage

// File: wishbone/wishbone_decoder.sv
// ##################################################
// Combinational strobe routing and return mux
// Unmapped requests get a registered ack with UNMAPPED_DATA
// ##################################################
`timescale 1ns/1ps

module wishbone_decoder (
    input  logic                                 wb_clk_i,
    input  logic                                 reset_i,
    input  logic                                 wbs_cyc_i,
    input  logic                                 wbs_stb_i,
    input  logic [31:0]                          wbs_adr_i,
    output logic                                 sram_stb_o,
    output logic                                 gpio_stb_o,
    output logic                                 la_stb_o,
    output logic [nebula_pkg::NUM_TEAMS-1:0]     team_stb_o,
    input  logic                                 sram_ack_i,
    input  logic                                 gpio_ack_i,
    input  logic                                 la_ack_i,
    input  logic [nebula_pkg::NUM_TEAMS-1:0]     team_ack_i,
    input  logic [31:0]                          sram_dat_i,
    input  logic [31:0]                          gpio_dat_i,
    input  logic [31:0]                          la_dat_i,
    input  logic [32*nebula_pkg::NUM_TEAMS-1:0]  team_dat_i,
    output logic                                 wbs_ack_o,
    output logic [31:0]                          wbs_dat_o
);
    import nebula_pkg::*;

    localparam int UNM = NUM_TEAMS + 3;  // Unmapped bit of the one-hot target

    wb_addr_u             adr;
    logic                 req;
    logic                 hit_sram, hit_gpio, hit_la, unmapped;
    logic [NUM_TEAMS-1:0] hit_team;
    logic [UNM:0]         target_q;     // sram, gpio, la, teams, unmapped
    logic                 unm_ack_q;

    assign adr = wbs_adr_i;
    assign req = wbs_cyc_i & wbs_stb_i;

    always_comb begin
        hit_sram = adr.sys_view.region == REGION_SRAM && adr.sys_view.word < SRAM_WORDS;
        hit_gpio = adr.sys_view.region == REGION_GPIO;
        hit_la   = adr.sys_view.region == REGION_LA;
        // Team index 0 and anything above NUM_TEAMS falls through
        for (int t = 0; t < NUM_TEAMS; t++) begin
            hit_team[t] = adr.team_view.region == REGION_TEAM && adr.team_view.team == t + 1;
        end
        unmapped = ~(hit_sram | hit_gpio | hit_la | (|hit_team));
    end

    assign sram_stb_o = req & hit_sram;
    assign gpio_stb_o = req & hit_gpio;
    assign la_stb_o   = req & hit_la;
    assign team_stb_o = {NUM_TEAMS{req}} & hit_team;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            unm_ack_q <= 1'b0;
            target_q  <= '0;
        end else begin
            unm_ack_q <= req & unmapped & ~unm_ack_q;  // One ack per held request
            if (req) target_q <= {unmapped, hit_team, hit_la, hit_gpio, hit_sram};
        end
    end

    assign wbs_ack_o = sram_ack_i | gpio_ack_i | la_ack_i | (|team_ack_i) | unm_ack_q;

    always_comb begin
        wbs_dat_o = '0;
        if (target_q[0]) wbs_dat_o = sram_dat_i;
        if (target_q[1]) wbs_dat_o = gpio_dat_i;
        if (target_q[2]) wbs_dat_o = la_dat_i;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            if (target_q[3+t]) wbs_dat_o = team_dat_i[32*t +: 32];
        end
        if (target_q[UNM]) wbs_dat_o = UNMAPPED_DATA;
    end

endmodule

// File: design/sram_wb.sv
// ##################################################
// 256 x 32 word SRAM, no reset of contents
// ##################################################
`timescale 1ns/1ps

module sram_wb (
    input  logic        wb_clk_i,
    input  logic        reset_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o
);
    import nebula_pkg::*;

    logic [31:0] mem [SRAM_WORDS];
    logic [7:0]  idx;
    logic        take;

    assign idx  = adr_i[9:2];     // Word address
    assign take = stb_i & ~ack_o; // Strobe ignored while acking

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= take;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) begin
            if (we_i) mem[idx] <= byte_merge(mem[idx], dat_i, sel_i);
            dat_o <= mem[idx];
        end
    end

endmodule

// File: control/gpio_control.sv
// ##################################################
// Owner field per 8-pin bank in bits 19:0
// Owners above NUM_TEAMS read back as written but drive the no-owner slot
// ##################################################
`timescale 1ns/1ps

module gpio_control (
    input  logic        wb_clk_i,
    input  logic        reset_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    input  logic [nebula_pkg::GPIO_PINS*(nebula_pkg::NUM_TEAMS+1)-1:0] designs_gpio_out_flat_i,
    input  logic [nebula_pkg::GPIO_PINS*(nebula_pkg::NUM_TEAMS+1)-1:0] designs_gpio_oeb_flat_i,
    output logic [nebula_pkg::GPIO_PINS-1:0] gpio_out_o,
    output logic [nebula_pkg::GPIO_PINS-1:0] gpio_oeb_o
);
    import nebula_pkg::*;

    localparam int OWNER_BITS = 4 * GPIO_BANKS;

    logic [OWNER_BITS-1:0] owner_q;
    logic [31:0]           owner_next;
    logic [3:0]            owner_eff [GPIO_BANKS];
    logic                  take;

    assign take       = stb_i & ~ack_o;
    assign owner_next = byte_merge(32'(owner_q), dat_i, sel_i);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o   <= 1'b0;
            owner_q <= '0;
        end else begin
            ack_o <= take;
            if (take && we_i) owner_q <= owner_next[OWNER_BITS-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) dat_o <= 32'(owner_q);
    end

    always_comb begin
        for (int b = 0; b < GPIO_BANKS; b++) begin
            owner_eff[b] = owner_q[4*b +: 4];
            if (owner_eff[b] > NUM_TEAMS) owner_eff[b] = '0;
        end
    end

    // Each pin follows the slot that owns its bank
    always_comb begin
        for (int p = 0; p < GPIO_PINS; p++) begin
            gpio_out_o[p] = designs_gpio_out_flat_i[owner_eff[p / GPIO_BANK] * GPIO_PINS + p];
            gpio_oeb_o[p] = designs_gpio_oeb_flat_i[owner_eff[p / GPIO_BANK] * GPIO_PINS + p];
        end
    end

endmodule

// File: control/la_control.sv
// ##################################################
// Owner field per 32-bit LA bank in bits 15:0
// ##################################################
`timescale 1ns/1ps

module la_control (
    input  logic        wb_clk_i,
    input  logic        reset_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    input  logic [nebula_pkg::LA_WIDTH*(nebula_pkg::NUM_TEAMS+1)-1:0] designs_la_data_out_flat_i,
    output logic [nebula_pkg::LA_WIDTH-1:0] la_data_o
);
    import nebula_pkg::*;

    logic [4*LA_BANKS-1:0] owner_q;
    logic [31:0]           owner_next;
    logic [3:0]            owner_eff;
    logic                  take;

    assign take       = stb_i & ~ack_o;
    assign owner_next = byte_merge(32'(owner_q), dat_i, sel_i);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o   <= 1'b0;
            owner_q <= '0;
        end else begin
            ack_o <= take;
            if (take && we_i) owner_q <= owner_next[4*LA_BANKS-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) dat_o <= 32'(owner_q);
    end

    always_comb begin
        for (int b = 0; b < LA_BANKS; b++) begin
            owner_eff = owner_q[4*b +: 4];
            if (owner_eff > NUM_TEAMS) owner_eff = '0;  // Unknown team drives zeros
            la_data_o[32*b +: 32] = designs_la_data_out_flat_i[owner_eff*LA_WIDTH + 32*b +: 32];
        end
    end

endmodule

// File: design/sample_team.sv
// ##################################################
// Sample team with scratch, counter, control and id registers
// Counter runs while en_i and control bit 0 are both high
// ##################################################
`timescale 1ns/1ps

module sample_team #(
    parameter int TEAM_ID = 1
) (
    input  logic        wb_clk_i,
    input  logic        reset_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    input  logic        en_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    output logic [nebula_pkg::GPIO_PINS-1:0] gpio_out_o,
    output logic [nebula_pkg::GPIO_PINS-1:0] gpio_oeb_o,
    output logic [nebula_pkg::LA_WIDTH-1:0]  la_data_o
);
    import nebula_pkg::*;

    wb_addr_u    adr;
    logic [31:0] scratch_q, counter_q, control_q;
    logic        take, wr;

    assign adr  = adr_i;
    assign take = stb_i & ~ack_o;
    assign wr   = take & we_i;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ack_o     <= 1'b0;
            scratch_q <= '0;
            counter_q <= '0;
            control_q <= '0;
        end else begin
            ack_o <= take;
            if (wr && adr.team_view.reg_num == 6'd0) scratch_q <= byte_merge(scratch_q, dat_i, sel_i);
            if (wr && adr.team_view.reg_num == 6'd1) begin
                counter_q <= byte_merge(counter_q, dat_i, sel_i);  // Load beats count
            end else if (en_i && control_q[0]) begin
                counter_q <= counter_q + 32'd1;
            end
            if (wr && adr.team_view.reg_num == 6'd2) control_q <= byte_merge(control_q, dat_i, sel_i);
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (take) begin
            case (adr.team_view.reg_num)
                6'd0:    dat_o <= scratch_q;
                6'd1:    dat_o <= counter_q;
                6'd2:    dat_o <= control_q;
                6'd3:    dat_o <= 32'(TEAM_ID);
                default: dat_o <= '0;
            endcase
        end
    end

    assign gpio_out_o = GPIO_PINS'(scratch_q ^ counter_q);
    assign gpio_oeb_o = '0;  // Always driving
    assign la_data_o  = {32'(TEAM_ID), control_q, scratch_q, counter_q};

endmodule

// File: design/nebula_ii.sv
// ##################################################
// Single Wishbone manager, no arbiter; every target acks one cycle after strobe
// ##################################################
`timescale 1ns/1ps

module nebula_ii (
    input  logic                                wb_clk_i,
    input  logic                                reset_i,
    input  logic                                wbs_cyc_i,
    input  logic                                wbs_stb_i,
    input  logic                                wbs_we_i,
    input  logic [3:0]                          wbs_sel_i,
    input  logic [31:0]                         wbs_adr_i,
    input  logic [31:0]                         wbs_dat_i,
    input  logic                                en_i,
    output logic                                wbs_ack_o,
    output logic [31:0]                         wbs_dat_o,
    output logic [nebula_pkg::GPIO_PINS-1:0]    io_out_o,
    output logic [nebula_pkg::GPIO_PINS-1:0]    io_oeb_o,
    output logic [nebula_pkg::LA_WIDTH-1:0]     la_data_o
);
    import nebula_pkg::*;

    logic                    sram_stb, gpio_stb, la_stb;
    logic                    sram_ack, gpio_ack, la_ack;
    logic [31:0]             sram_dat, gpio_dat, la_dat;
    logic [NUM_TEAMS-1:0]    team_stb;
    logic [NUM_TEAMS-1:0]    team_ack;
    logic [32*NUM_TEAMS-1:0] team_dat;

    // Per-team pin outputs, slot 0 is the no-owner default
    logic [GPIO_PINS-1:0] team_gpio_out [NUM_TEAMS+1];
    logic [GPIO_PINS-1:0] team_gpio_oeb [NUM_TEAMS+1];
    logic [LA_WIDTH-1:0]  team_la_out [NUM_TEAMS+1];

    logic [GPIO_PINS*(NUM_TEAMS+1)-1:0] gpio_out_flat;
    logic [GPIO_PINS*(NUM_TEAMS+1)-1:0] gpio_oeb_flat;
    logic [LA_WIDTH*(NUM_TEAMS+1)-1:0]  la_out_flat;

    assign team_gpio_out[0] = '0;
    assign team_gpio_oeb[0] = '1;  // Unowned pins stay inputs
    assign team_la_out[0]   = '0;

    always_comb begin
        for (int t = 0; t <= NUM_TEAMS; t++) begin
            gpio_out_flat[t*GPIO_PINS +: GPIO_PINS] = team_gpio_out[t];
            gpio_oeb_flat[t*GPIO_PINS +: GPIO_PINS] = team_gpio_oeb[t];
            la_out_flat[t*LA_WIDTH +: LA_WIDTH]     = team_la_out[t];
        end
    end

    wishbone_decoder u_decoder (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .wbs_cyc_i  (wbs_cyc_i),
        .wbs_stb_i  (wbs_stb_i),
        .wbs_adr_i  (wbs_adr_i),
        .sram_stb_o (sram_stb),
        .gpio_stb_o (gpio_stb),
        .la_stb_o   (la_stb),
        .team_stb_o (team_stb),
        .sram_ack_i (sram_ack),
        .gpio_ack_i (gpio_ack),
        .la_ack_i   (la_ack),
        .team_ack_i (team_ack),
        .sram_dat_i (sram_dat),
        .gpio_dat_i (gpio_dat),
        .la_dat_i   (la_dat),
        .team_dat_i (team_dat),
        .wbs_ack_o  (wbs_ack_o),
        .wbs_dat_o  (wbs_dat_o)
    );

    sram_wb u_sram (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .stb_i    (sram_stb),
        .we_i     (wbs_we_i),
        .sel_i    (wbs_sel_i),
        .adr_i    (wbs_adr_i),
        .dat_i    (wbs_dat_i),
        .ack_o    (sram_ack),
        .dat_o    (sram_dat)
    );

    gpio_control u_gpio (
        .wb_clk_i                (wb_clk_i),
        .reset_i                 (reset_i),
        .stb_i                   (gpio_stb),
        .we_i                    (wbs_we_i),
        .sel_i                   (wbs_sel_i),
        .dat_i                   (wbs_dat_i),
        .ack_o                   (gpio_ack),
        .dat_o                   (gpio_dat),
        .designs_gpio_out_flat_i (gpio_out_flat),
        .designs_gpio_oeb_flat_i (gpio_oeb_flat),
        .gpio_out_o              (io_out_o),
        .gpio_oeb_o              (io_oeb_o)
    );

    la_control u_la (
        .wb_clk_i                   (wb_clk_i),
        .reset_i                    (reset_i),
        .stb_i                      (la_stb),
        .we_i                       (wbs_we_i),
        .sel_i                      (wbs_sel_i),
        .dat_i                      (wbs_dat_i),
        .ack_o                      (la_ack),
        .dat_o                      (la_dat),
        .designs_la_data_out_flat_i (la_out_flat),
        .la_data_o                  (la_data_o)
    );

    for (genvar t = 0; t < NUM_TEAMS; t++) begin : g_team
        sample_team #(
            .TEAM_ID(t + 1)
        ) u_team (
            .wb_clk_i   (wb_clk_i),
            .reset_i    (reset_i),
            .stb_i      (team_stb[t]),
            .we_i       (wbs_we_i),
            .sel_i      (wbs_sel_i),
            .adr_i      (wbs_adr_i),
            .dat_i      (wbs_dat_i),
            .en_i       (en_i),
            .ack_o      (team_ack[t]),
            .dat_o      (team_dat[32*t +: 32]),
            .gpio_out_o (team_gpio_out[t+1]),
            .gpio_oeb_o (team_gpio_oeb[t+1]),
            .la_data_o  (team_la_out[t+1])
        );
    end

endmodule

// File: sim/tb_clock.sv
// ##################################################
// Free-running clock, starts low
// ##################################################
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;
endmodule

// File: sim/nebula_ii_tb.sv
// ##################################################
// Bus driven on falling edges with one request in flight
// SRAM bytes never written are masked out of compares
// ##################################################
`timescale 1ns/1ps

module nebula_ii_tb;
    import nebula_pkg::*;

    localparam int CLK_NS       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int ACK_LIMIT    = 50;
    localparam int REQ_CYCLES   = 2;   // Idle cycle plus one-cycle ack
    localparam int SRAM_OPS     = 64;
    localparam int OWN_STEPS    = 6;
    localparam int RAND_STEP    = 4;   // Owner step with random words
    localparam int REQ_TOTAL    = 2 + 2 * SRAM_OPS + 6 + 5 * NUM_TEAMS + 4 * OWN_STEPS + 10;

    localparam logic [31:0] GPIO_ADR = 32'h0000_1000;
    localparam logic [31:0] LA_ADR   = 32'h0000_2000;

    // Nibbles above NUM_TEAMS mean no owner
    localparam logic [19:0] GPIO_OWN_SET [OWN_STEPS] = '{20'h11111, 20'h22222, 20'h01272,
                                                         20'h21021, 20'h00000, 20'h77777};
    localparam logic [15:0] LA_OWN_SET [OWN_STEPS] = '{16'h1111, 16'h2222, 16'h7120,
                                                       16'h0212, 16'h0000, 16'h2171};

    logic                 clk;
    logic                 reset_i;
    logic                 wbs_cyc_i, wbs_stb_i, wbs_we_i;
    logic [3:0]           wbs_sel_i;
    logic [31:0]          wbs_adr_i, wbs_dat_i;
    logic                 en_i;
    logic                 wbs_ack_o;
    logic [31:0]          wbs_dat_o;
    logic [GPIO_PINS-1:0] io_out_o, io_oeb_o;
    logic [LA_WIDTH-1:0]  la_data_o;

    // Reference model
    logic [31:0]             sram_m [SRAM_WORDS];
    logic [3:0]              sram_v [SRAM_WORDS];  // Bytes written so far
    logic [4*GPIO_BANKS-1:0] gpio_own;
    logic [4*LA_BANKS-1:0]   la_own;
    logic [31:0]             team_scr [NUM_TEAMS+1];
    logic [31:0]             team_cnt [NUM_TEAMS+1];
    logic [31:0]             team_ctl [NUM_TEAMS+1];

    event        req_done;
    string       test_name;
    string       rec_name;
    logic        rec_we;
    logic [31:0] rec_adr, rec_dat;
    int          rec_lat;
    logic        rec_cmp_data, rec_cmp_pins;
    logic        data_checked, pins_live;
    int          fails;
    logic [31:0] lfsr_q = 32'h54a6;

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk_o(clk));

    nebula_ii uut (
        .wb_clk_i  (clk),
        .reset_i   (reset_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .en_i      (en_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .io_out_o  (io_out_o),
        .io_oeb_o  (io_oeb_o),
        .la_data_o (la_data_o)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] apply_sel(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] sel);
        logic [31:0] v;
        for (int b = 0; b < 4; b++) begin
            v[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return v;
    endfunction

    function automatic int owner_of(input logic [3:0] f);
        return (int'(f) > NUM_TEAMS) ? 0 : int'(f);
    endfunction

    function automatic logic [31:0] team_adr(input int t, input int r);
        return {16'h0, REGION_TEAM, 4'(t), 6'(r), 2'b00};
    endfunction

    function automatic logic [31:0] team_reg(input int t, input int r);
        logic [31:0] v;
        case (r)
            0:       v = team_scr[t];
            1:       v = team_cnt[t];
            2:       v = team_ctl[t];
            3:       v = 32'(t);
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] adr);
        logic [31:0] v;
        int          tm;
        tm = int'(adr[11:8]);
        case (adr[15:12])
            REGION_SRAM: v = (adr[11:10] == 2'b00) ? sram_m[adr[9:2]] : UNMAPPED_DATA;
            REGION_GPIO: v = 32'(gpio_own);
            REGION_LA:   v = 32'(la_own);
            REGION_TEAM: v = (tm >= 1 && tm <= NUM_TEAMS) ? team_reg(tm, int'(adr[7:2]))
                                                           : UNMAPPED_DATA;
            default:     v = UNMAPPED_DATA;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] sram_mask(input logic [31:0] adr);
        logic [31:0] m;
        m = '1;
        if (adr[15:12] == REGION_SRAM && adr[11:10] == 2'b00) begin
            for (int b = 0; b < 4; b++) m[8*b +: 8] = {8{sram_v[adr[9:2]][b]}};
        end
        return m;
    endfunction

    function automatic logic [GPIO_PINS-1:0] pins_model(input logic want_oeb);
        logic [GPIO_PINS-1:0] v;
        logic [GPIO_PINS-1:0] w;
        int                   t;
        for (int p = 0; p < GPIO_PINS; p++) begin
            t = owner_of(gpio_own[4*(p/GPIO_BANK) +: 4]);
            w = (t == 0) ? '0 : GPIO_PINS'(team_scr[t] ^ team_cnt[t]);
            v[p] = want_oeb ? (t == 0) : w[p];  // Teams always drive
        end
        return v;
    endfunction

    function automatic logic [LA_WIDTH-1:0] la_model();
        logic [LA_WIDTH-1:0] v;
        int                  t;
        for (int b = 0; b < LA_BANKS; b++) begin
            t = owner_of(la_own[4*b +: 4]);
            // LA words are counter, scratch, control, id
            v[32*b +: 32] = (t == 0) ? '0 : team_reg(t, (b < 2) ? 1 - b : b);
        end
        return v;
    endfunction

    task automatic model_write(input logic [31:0] adr, input logic [31:0] dat,
                               input logic [3:0] sel);
        logic [31:0] w;
        int          tm;
        int          rn;
        tm = int'(adr[11:8]);
        rn = int'(adr[7:2]);
        case (adr[15:12])
            REGION_SRAM: begin
                if (adr[11:10] == 2'b00) begin
                    sram_m[adr[9:2]] = apply_sel(sram_m[adr[9:2]], dat, sel);
                    sram_v[adr[9:2]] = sram_v[adr[9:2]] | sel;
                end
            end
            REGION_GPIO: begin
                w = apply_sel(32'(gpio_own), dat, sel);
                gpio_own = w[4*GPIO_BANKS-1:0];
            end
            REGION_LA: begin
                w = apply_sel(32'(la_own), dat, sel);
                la_own = w[4*LA_BANKS-1:0];
            end
            REGION_TEAM: begin
                if (tm >= 1 && tm <= NUM_TEAMS) begin
                    if (rn == 0) team_scr[tm] = apply_sel(team_scr[tm], dat, sel);
                    if (rn == 1) team_cnt[tm] = apply_sel(team_cnt[tm], dat, sel);
                    if (rn == 2) team_ctl[tm] = apply_sel(team_ctl[tm], dat, sel);
                end
            end
            default: ;
        endcase
    endtask

    task automatic fail_run();
        fails++;
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [31:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int cycles;
        cycles = 0;
        @(negedge clk);
        check_value({test_name, " ack idle"}, 128'(0), 128'(wbs_ack_o));  // One-cycle ack
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = write;
        wbs_sel_i = sel;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        do begin
            @(negedge clk);
            cycles++;
        end while (wbs_ack_o !== 1'b1 && cycles < ACK_LIMIT);
        if (wbs_ack_o !== 1'b1) begin
            $display("No ack from address %h within %0d cycles", adr, ACK_LIMIT);
            fail_run();
        end else begin
            rdat      = wbs_dat_o;
            wbs_cyc_i = 1'b0;
            wbs_stb_i = 1'b0;
            wbs_we_i  = 1'b0;
            if (write) model_write(adr, wdat, sel);
            rec_name     = test_name;
            rec_we       = write;
            rec_adr      = adr;
            rec_dat      = rdat;
            rec_lat      = cycles;
            rec_cmp_data = data_checked;
            rec_cmp_pins = pins_live;
            -> req_done;
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
        logic [31:0] ignored;
        bus_cycle(1'b1, adr, dat, sel, ignored);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, '0, 4'hf, dat);
    endtask

    always @(req_done) begin : compare
        logic [31:0] mask;
        check_value({rec_name, " ack latency"}, 128'(1), 128'(rec_lat));
        if (!rec_we && rec_cmp_data) begin
            mask = sram_mask(rec_adr);
            check_value(rec_name, 128'(ref_read(rec_adr) & mask), 128'(rec_dat & mask));
        end
        if (rec_we && rec_cmp_pins) begin
            check_value({rec_name, " io_out"}, 128'(pins_model(1'b0)), 128'(io_out_o));
            check_value({rec_name, " io_oeb"}, 128'(pins_model(1'b1)), 128'(io_oeb_o));
            check_value({rec_name, " la_data"}, 128'(la_model()), 128'(la_data_o));
        end
    end

    initial begin : watchdog
        #(REQ_TOTAL * 20 * CLK_NS + RESET_CYCLES * CLK_NS);
        $display("Watchdog expired before all requests were done");
        fail_run();
    end

    initial begin : stimulus
        logic [7:0]  sram_w [SRAM_OPS];
        logic [31:0] d, c0, c1, c2, c3;
        logic [3:0]  sel;
        logic [19:0] g_own;
        logic [15:0] l_own;

        reset_i      = 1'b1;
        wbs_cyc_i    = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = 4'h0;
        wbs_adr_i    = '0;
        wbs_dat_i    = '0;
        en_i         = 1'b0;
        fails        = 0;
        data_checked = 1'b1;
        pins_live    = 1'b1;
        gpio_own     = '0;
        la_own       = '0;
        for (int i = 0; i < SRAM_WORDS; i++) begin
            sram_m[i] = '0;
            sram_v[i] = '0;
        end
        for (int t = 0; t <= NUM_TEAMS; t++) begin
            team_scr[t] = '0;
            team_cnt[t] = '0;
            team_ctl[t] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset_i = 1'b0;

        test_name = "reset";
        check_value("reset io_oeb", 128'({GPIO_PINS{1'b1}}), 128'(io_oeb_o));
        check_value("reset io_out", '0, 128'(io_out_o));
        check_value("reset la_data", '0, 128'(la_data_o));
        wb_read(GPIO_ADR, d);
        wb_read(LA_ADR, d);

        test_name = "sram";
        for (int i = 0; i < SRAM_OPS; i++) begin
            sram_w[i] = (i == SRAM_OPS - 1) ? 8'hff : 8'(rand_bits(8));  // Top word last
            sel = (i == SRAM_OPS - 1) ? 4'hf : 4'(rand_bits(4));
            wb_write({22'h0, sram_w[i], 2'b00}, rand_bits(32), sel);
        end

        // Misses in between must not alias onto SRAM word 255 or team 1
        test_name = "unmapped";
        wb_read(32'h0000_53fc, d);
        wb_write(32'h0000_53fc, rand_bits(32), 4'hf);
        wb_read(32'h0000_3304, d);
        wb_write(32'h0000_3300, rand_bits(32), 4'hf);
        wb_read(team_adr(1, 0), d);
        wb_read(32'h0000_0400, d);   // SRAM word 256

        test_name = "sram";
        for (int i = 0; i < SRAM_OPS; i++) wb_read({22'h0, sram_w[i], 2'b00}, d);

        test_name = "team";
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            wb_write(team_adr(t, 0), rand_bits(32), 4'hf);
            wb_write(team_adr(t, 1), rand_bits(32), 4'hf);
            wb_read(team_adr(t, 0), d);
            wb_read(team_adr(t, 1), d);
            wb_read(team_adr(t, 3), d);
        end

        test_name = "owner";
        for (int i = 0; i < OWN_STEPS; i++) begin
            g_own = (i == RAND_STEP) ? 20'(rand_bits(20)) : GPIO_OWN_SET[i];
            l_own = (i == RAND_STEP) ? 16'(rand_bits(16)) : LA_OWN_SET[i];
            wb_write(GPIO_ADR, 32'(g_own), 4'hf);
            wb_write(LA_ADR, 32'(l_own), 4'hf);
            wb_read(GPIO_ADR, d);
            wb_read(LA_ADR, d);
        end

        test_name = "count";
        wb_write(team_adr(1, 2), 32'h1, 4'hf);
        pins_live    = 1'b0;  // Team pins follow the running counter
        data_checked = 1'b0;
        en_i         = 1'b1;
        wb_read(team_adr(1, 1), c0);
        repeat (3) wb_read(team_adr(1, 0), d);
        wb_read(team_adr(1, 1), c1);
        check_value("count enabled", 128'(REQ_CYCLES * 4), 128'(c1 - c0));
        en_i = 1'b0;
        wb_read(team_adr(1, 1), c2);
        repeat (2) wb_read(team_adr(1, 0), d);
        wb_read(team_adr(1, 1), c3);
        check_value("count held", 128'(c2), 128'(c3));

        @(negedge clk);  // Last compare done
        if (fails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: nebula_ii.f
common/nebula_pkg.sv
wishbone/wishbone_decoder.sv
design/sram_wb.sv
control/gpio_control.sv
control/la_control.sv
design/sample_team.sv
design/nebula_ii.sv
sim/tb_clock.sv
sim/nebula_ii_tb.sv

// File: Makefile
# Verilator build and run of the nebula_ii testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module nebula_ii_tb \
		-f nebula_ii.f -o nebula_ii_sim
	./obj_dir/nebula_ii_sim > $(LOG) 2>&1; true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
